// File: hdl/yuv420_pkg.sv
package yuv420_pkg;

   // stream type codes
   localparam int dtype_width = 4;
   localparam logic [dtype_width-1:0] dtype_frame_start  = 4'd1;
   localparam logic [dtype_width-1:0] dtype_frame_end    = 4'd2;
   localparam logic [dtype_width-1:0] dtype_header_start = 4'd3;
   localparam logic [dtype_width-1:0] dtype_header       = 4'd4;
   localparam logic [dtype_width-1:0] dtype_header_end   = 4'd5;
   localparam logic [dtype_width-1:0] dtype_row_start    = 4'd6;
   localparam logic [dtype_width-1:0] dtype_row_end      = 4'd7;
   localparam logic [dtype_width-1:0] dtype_pixel        = 4'd8;

   // any type sharing a bit with this mask is a pixel beat
   localparam logic [dtype_width-1:0] dtype_pixel_mask   = 4'd8;

   // frame geometry
   localparam int max_cols  = 1288;
   localparam int dim_width = 11;
   localparam logic [dim_width-1:0] reset_num_rows = 11'd720;
   localparam logic [dim_width-1:0] reset_num_cols = 11'd1280;

   // raw mode keeps the upper bits of the metadata
   localparam int raw_pixel_shift = 2;
   localparam logic [15:0] image_type_raw = 16'd0;

   // header beat whose value is swapped for image_type
   localparam int header_type_slot = 2;

   // output word and largest per-beat contribution
   localparam int word_width     = 32;
   localparam int beat_bytes_max = 3;

endpackage

// File: hdl/beat_if.sv
`timescale 1ns/1ps

interface beat_if
   import yuv420_pkg::*;
   ();

   logic                        dv;
   logic [dtype_width-1:0]      dtype;
   // first byte in stream order sits in the top lane
   logic [8*beat_bytes_max-1:0] bytes;
   logic [1:0]                  len;
   logic [15:0]                 meta;

   modport src (
      output dv, dtype, bytes, len, meta
   );

   modport dst (
      input dv, dtype, bytes, len, meta
   );

endinterface

// File: hdl/frame_position.sv
`timescale 1ns/1ps

module frame_position
   import yuv420_pkg::*;
   (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   dvi,
   input  logic [dtype_width-1:0] dtypei,
   output logic [dim_width-1:0]   col_idx,
   output logic                   row_odd,
   output logic                   col_odd,
   output logic [dim_width-1:0]   num_rows,
   output logic [dim_width-1:0]   num_cols
   );

   logic [dim_width-1:0] row_cnt;
   logic [dim_width-1:0] col_cnt;
   logic                 pixel_in;

   assign pixel_in = dvi && |(dtypei & dtype_pixel_mask);

   // position of the beat currently on the input
   assign col_idx = col_cnt;
   assign row_odd = row_cnt[0];
   assign col_odd = col_cnt[0];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_cnt  <= '0;
         col_cnt  <= '0;
         num_rows <= reset_num_rows;
         num_cols <= reset_num_cols;
      end else if (dvi) begin
         if (pixel_in) begin
            col_cnt <= col_cnt + 1'b1;
         end else if (dtypei == dtype_row_start) begin
            col_cnt <= '0;
         end

         if (dtypei == dtype_row_end) begin
            row_cnt <= row_cnt + 1'b1;
         end else if (dtypei == dtype_frame_start) begin
            row_cnt <= '0;
         end else if (dtypei == dtype_frame_end) begin
            // measured size, rounded down to even
            num_rows <= {row_cnt[dim_width-1:1], 1'b0};
            num_cols <= {col_cnt[dim_width-1:1], 1'b0};
         end
      end
   end

   // a row longer than the line buffer would overrun it
   assert property (@(posedge clk) disable iff (!resetb)
      pixel_in |-> (col_cnt < dim_width'(max_cols)));

endmodule

// File: hdl/chroma_subsampler.sv
`timescale 1ns/1ps

module chroma_subsampler
   import yuv420_pkg::*;
   (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic [15:0]            image_type,
   input  logic                   enable_420,
   input  logic                   dvi,
   input  logic [dtype_width-1:0] dtypei,
   input  logic [15:0]            meta_datai,
   input  logic [7:0]             yi,
   input  logic [7:0]             ui,
   input  logic [7:0]             vi,
   input  logic [dim_width-1:0]   col_idx,
   input  logic                   row_odd,
   input  logic                   col_odd,
   beat_if.src                    beat
   );

   // previous row's U,V per column
   logic [15:0] line_buf [max_cols];

   logic                        pixel_in;
   logic [15:0]                 up_uv;
   logic [15:0]                 left_uv;
   logic [15:0]                 diag_uv;
   logic [9:0]                  u_sum;
   logic [9:0]                  v_sum;
   logic [15:0]                 meta_shift;
   logic [8*beat_bytes_max-1:0] fmt_bytes;
   logic [1:0]                  fmt_len;

   assign pixel_in = dvi && |(dtypei & dtype_pixel_mask);
   assign up_uv    = line_buf[col_idx];

   always_ff @(posedge clk) begin
      if (pixel_in) begin
         line_buf[col_idx] <= {ui, vi};
      end
   end

   // left and up-left neighbours complete the 2x2 kernel
   always_ff @(posedge clk) begin
      if (pixel_in) begin
         left_uv <= {ui, vi};
         diag_uv <= up_uv;
      end
   end

   assign u_sum = 10'(ui) + 10'(up_uv[15:8]) + 10'(left_uv[15:8]) + 10'(diag_uv[15:8]);
   assign v_sum = 10'(vi) + 10'(up_uv[7:0]) + 10'(left_uv[7:0]) + 10'(diag_uv[7:0]);

   assign meta_shift = meta_datai >> raw_pixel_shift;

   always_comb begin
      if (!pixel_in) begin
         fmt_bytes = '0;
         fmt_len   = 2'd0;
      end else if (image_type == image_type_raw) begin
         fmt_bytes = {meta_shift[7:0], 16'h0000};
         fmt_len   = 2'd1;
      end else if (!enable_420) begin
         fmt_bytes = {yi, ui, vi};
         fmt_len   = 2'd3;
      end else if (row_odd && col_odd) begin
         // Y followed by the kernel mean of U and V
         fmt_bytes = {yi, u_sum[9:2], v_sum[9:2]};
         fmt_len   = 2'd3;
      end else begin
         fmt_bytes = {yi, 16'h0000};
         fmt_len   = 2'd1;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beat.dv    <= 1'b0;
         beat.dtype <= '0;
         beat.len   <= 2'd0;
      end else begin
         beat.dv    <= dvi;
         beat.dtype <= dtypei;
         beat.len   <= fmt_len;
      end
   end

   always_ff @(posedge clk) begin
      beat.bytes <= fmt_bytes;
      beat.meta  <= meta_datai;
   end

   assert property (@(posedge clk) disable iff (!resetb)
      (beat.dv && |(beat.dtype & dtype_pixel_mask)) |-> (beat.len != 2'd0));

endmodule

// File: hdl/word_packer.sv
`timescale 1ns/1ps

module word_packer
   import yuv420_pkg::*;
   (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic [15:0]            image_type,
   beat_if.dst                    beat,
   output logic                   dvo,
   output logic [dtype_width-1:0] dtypeo,
   output logic [word_width-1:0]  datao
   );

   localparam int acc_width = word_width + 8*beat_bytes_max;

   // newest byte sits in the low lane
   logic [acc_width-1:0]  acc;
   logic [acc_width-1:0]  next_acc;
   logic [2:0]            fill;
   logic [2:0]            next_fill;
   logic [7:0]            hdr_pos;
   logic [15:0]           hdr_low;
   logic [15:0]           hdr_val;
   logic                  flushed;
   logic                  pixel_beat;
   logic                  flush_req;
   logic [word_width-1:0] full_word;
   logic [word_width-1:0] flush_word;

   function automatic logic [word_width-1:0] oldest_low(input logic [word_width-1:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   assign pixel_beat = beat.dv && |(beat.dtype & dtype_pixel_mask);
   assign flush_req  = beat.dv && (beat.dtype == dtype_frame_end) && (fill != 3'd0);

   always_comb begin
      if (beat.len == 2'd3) begin
         next_acc = {acc[acc_width-25:0], beat.bytes};
      end else begin
         next_acc = {acc[acc_width-9:0], beat.bytes[23:16]};
      end
      next_fill = fill + {1'b0, beat.len};
   end

   // top four bytes of the accumulator once at least four are held
   assign full_word = word_width'(next_acc >> {next_fill - 3'd4, 3'b000});

   // leftover bytes moved up with zeros below them
   assign flush_word = acc[word_width-1:0] << {3'd4 - fill, 3'b000};

   assign hdr_val = (hdr_pos == 8'(header_type_slot)) ? image_type : beat.meta;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         acc     <= '0;
         fill    <= 3'd0;
         hdr_pos <= '0;
         hdr_low <= '0;
         flushed <= 1'b0;
         dvo     <= 1'b0;
         dtypeo  <= '0;
         datao   <= '0;
      end else begin
         flushed <= flush_req;
         if (flushed) begin
            // frame_end marker follows its flush word
            dvo    <= 1'b1;
            dtypeo <= dtype_frame_end;
            datao  <= '0;
         end else if (flush_req) begin
            dvo    <= 1'b1;
            dtypeo <= dtype_pixel;
            datao  <= oldest_low(flush_word);
            fill   <= 3'd0;
         end else if (pixel_beat) begin
            acc    <= next_acc;
            dtypeo <= dtype_pixel;
            if (next_fill >= 3'd4) begin
               dvo   <= 1'b1;
               datao <= oldest_low(full_word);
               fill  <= next_fill - 3'd4;
            end else begin
               dvo   <= 1'b0;
               datao <= '0;
               fill  <= next_fill;
            end
         end else if (beat.dv) begin
            dtypeo <= beat.dtype;
            case (beat.dtype)
               dtype_frame_start: begin
                  hdr_pos <= '0;
                  fill    <= 3'd0;
                  dvo     <= 1'b1;
                  datao   <= '0;
               end
               dtype_header_start: begin
                  hdr_pos <= '0;
                  dvo     <= 1'b1;
                  datao   <= '0;
               end
               dtype_header: begin
                  hdr_pos <= hdr_pos + 1'b1;
                  if (hdr_pos[0]) begin
                     dvo   <= 1'b1;
                     datao <= {hdr_val, hdr_low};
                  end else begin
                     hdr_low <= hdr_val;
                     dvo     <= 1'b0;
                     datao   <= '0;
                  end
               end
               default: begin
                  // remaining markers pass through with zero data
                  dvo   <= 1'b1;
                  datao <= '0;
               end
            endcase
         end else begin
            dvo    <= 1'b0;
            dtypeo <= '0;
            datao  <= '0;
         end
      end
   end

   assert property (@(posedge clk) disable iff (!resetb)
      dvo |-> !$isunknown(dtypeo));

endmodule

// File: hdl/yuv420_stream.sv
`timescale 1ns/1ps

module yuv420_stream
   import yuv420_pkg::*;
   (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic [15:0]            image_type,
   input  logic                   enable_420,
   input  logic                   dvi,
   input  logic [dtype_width-1:0] dtypei,
   input  logic [15:0]            meta_datai,
   input  logic [7:0]             yi,
   input  logic [7:0]             ui,
   input  logic [7:0]             vi,
   output logic                   dvo,
   output logic [dtype_width-1:0] dtypeo,
   output logic [word_width-1:0]  datao,
   output logic [dim_width-1:0]   num_rows,
   output logic [dim_width-1:0]   num_cols
   );

   logic [dim_width-1:0] col_idx;
   logic                 row_odd;
   logic                 col_odd;

   // formatted beat, one cycle behind the input
   beat_if beat_bus ();

   frame_position u_frame_position (
      .clk      (clk),
      .resetb   (resetb),
      .dvi      (dvi),
      .dtypei   (dtypei),
      .col_idx  (col_idx),
      .row_odd  (row_odd),
      .col_odd  (col_odd),
      .num_rows (num_rows),
      .num_cols (num_cols)
   );

   chroma_subsampler u_chroma_subsampler (
      .clk        (clk),
      .resetb     (resetb),
      .image_type (image_type),
      .enable_420 (enable_420),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .meta_datai (meta_datai),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .col_idx    (col_idx),
      .row_odd    (row_odd),
      .col_odd    (col_odd),
      .beat       (beat_bus.src)
   );

   word_packer u_word_packer (
      .clk        (clk),
      .resetb     (resetb),
      .image_type (image_type),
      .beat       (beat_bus.dst),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao)
   );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic resetb
   );

   localparam real half_period  = 20.0;
   localparam int  reset_cycles = 8;

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // release lands just after a rising edge, like the other inputs
   initial begin
      resetb = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #2 resetb = 1'b1;
   end

endmodule

// File: verif/tb_yuv420_stream.sv
`timescale 1ns/1ps

module tb_yuv420_stream
   import yuv420_pkg::*;
   ();

   localparam int  gap_cycles  = 4;
   localparam int  total_beats = 4 * (8 + 4 * 8 + gap_cycles) + (8 + 3 * 7 + gap_cycles) + 16;
   localparam real watchdog_ns = total_beats * 40.0 * 2.0 + 2000.0;

   logic                   clk;
   logic                   resetb;
   logic [15:0]            image_type;
   logic                   enable_420;
   logic                   dvi;
   logic [dtype_width-1:0] dtypei;
   logic [15:0]            meta_datai;
   logic [7:0]             yi;
   logic [7:0]             ui;
   logic [7:0]             vi;
   logic                   dvo;
   logic [dtype_width-1:0] dtypeo;
   logic [word_width-1:0]  datao;
   logic [dim_width-1:0]   num_rows;
   logic [dim_width-1:0]   num_cols;

   int    seed       = 29374;
   int    errors     = 0;
   int    words_seen = 0;
   int    cycle      = 0;
   string test_name  = "reset";

   // predicted output words, in arrival order
   logic [dtype_width-1:0] exp_type_q [$];
   logic [word_width-1:0]  exp_data_q [$];
   int                     exp_cycle_q [$];
   string                  exp_test_q [$];
   // pixel bytes not yet making up a word
   logic [7:0]             byte_q [$];

   logic                   head_present = 1'b0;
   logic [dtype_width-1:0] head_type    = '0;
   logic [word_width-1:0]  head_data    = '0;
   int                     head_cycle   = 0;
   string                  head_test    = "";
   logic [dim_width-1:0]   exp_rows     = reset_num_rows;
   logic [dim_width-1:0]   exp_cols     = reset_num_cols;
   logic [15:0]            hdr_low;
   logic [7:0]             u_pix [0:3][0:5];
   logic [7:0]             v_pix [0:3][0:5];

   tb_clock_gen clock_gen (
      .clk    (clk),
      .resetb (resetb)
   );

   yuv420_stream DUT (
      .clk        (clk),
      .resetb     (resetb),
      .image_type (image_type),
      .enable_420 (enable_420),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .meta_datai (meta_datai),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao),
      .num_rows   (num_rows),
      .num_cols   (num_cols)
   );

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // outputs are stable here, pair each valid word with its prediction
   always @(negedge clk) begin
      head_present = 1'b0;
      if (resetb && dvo && exp_type_q.size() > 0) begin
         head_present = 1'b1;
         head_type    = exp_type_q.pop_front();
         head_data    = exp_data_q.pop_front();
         head_cycle   = exp_cycle_q.pop_front();
         head_test    = exp_test_q.pop_front();
         words_seen++;
      end
   end

   assert property (@(posedge clk) disable iff (!resetb) dvo |-> head_present)
      else begin
         errors++;
         $display("output word with dtype %0d arrived at cycle %0d when none was expected",
                  $sampled(dtypeo), $sampled(cycle));
      end

   assert property (@(posedge clk) disable iff (!resetb)
      (dvo && head_present) |-> (dtypeo == head_type))
      else begin
         errors++;
         $display("FAIL %s dtype expected %0d actual %0d", head_test, head_type, $sampled(dtypeo));
      end

   assert property (@(posedge clk) disable iff (!resetb)
      (dvo && head_present) |-> (datao == head_data))
      else begin
         errors++;
         $display("FAIL %s data expected %h actual %h", head_test, head_data, $sampled(datao));
      end

   assert property (@(posedge clk) disable iff (!resetb)
      (dvo && head_present) |-> (cycle == head_cycle))
      else begin
         errors++;
         $display("FAIL %s cycle expected %0d actual %0d", head_test, head_cycle, $sampled(cycle));
      end

   assert property (@(posedge clk) disable iff (!resetb) num_rows == exp_rows)
      else begin
         errors++;
         $display("FAIL %s num_rows expected %0d actual %0d", test_name, exp_rows,
                  $sampled(num_rows));
      end

   assert property (@(posedge clk) disable iff (!resetb) num_cols == exp_cols)
      else begin
         errors++;
         $display("FAIL %s num_cols expected %0d actual %0d", test_name, exp_cols,
                  $sampled(num_cols));
      end

   task automatic drive_beat(input logic [dtype_width-1:0] t, input logic [15:0] meta,
                             input logic [7:0] y, input logic [7:0] u, input logic [7:0] v);
      @(posedge clk);
      #2;
      dvi        = 1'b1;
      dtypei     = t;
      meta_datai = meta;
      yi         = y;
      ui         = u;
      vi         = v;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
         dvi        = 1'b0;
         dtypei     = '0;
         meta_datai = '0;
      end
   endtask

   task automatic expect_word(input logic [dtype_width-1:0] t,
                              input logic [word_width-1:0] d, input int delay);
      exp_type_q.push_back(t);
      exp_data_q.push_back(d);
      exp_cycle_q.push_back(cycle + delay);
      exp_test_q.push_back(test_name);
   endtask

   // four bytes make a word, oldest in the low lane
   task automatic add_byte(input logic [7:0] b);
      byte_q.push_back(b);
      if (byte_q.size() == 4) begin
         expect_word(dtype_pixel, {byte_q[3], byte_q[2], byte_q[1], byte_q[0]}, 2);
         byte_q.delete();
      end
   endtask

   task automatic send_marker(input logic [dtype_width-1:0] t);
      drive_beat(t, 16'h0000, 8'h00, 8'h00, 8'h00);
      expect_word(t, '0, 2);
   endtask

   task automatic send_header(input int idx);
      logic [15:0] meta;
      logic [15:0] val;
      meta = 16'($random(seed));
      drive_beat(dtype_header, meta, 8'h00, 8'h00, 8'h00);
      val = (idx == header_type_slot) ? image_type : meta;
      if (idx % 2 == 0) begin
         hdr_low = val;
      end else begin
         expect_word(dtype_header, {val, hdr_low}, 2);
      end
   endtask

   function automatic logic [7:0] kernel_mean(input logic [7:0] a, input logic [7:0] b,
                                              input logic [7:0] c, input logic [7:0] d);
      int sum;
      sum = int'(a) + int'(b) + int'(c) + int'(d);
      return 8'(sum / 4);
   endfunction

   task automatic send_pixel(input int r, input int c);
      logic [31:0] rnd;
      logic [15:0] meta;
      rnd  = $random(seed);
      meta = 16'($random(seed));
      u_pix[r][c] = rnd[15:8];
      v_pix[r][c] = rnd[7:0];
      drive_beat(dtype_pixel, meta, rnd[23:16], rnd[15:8], rnd[7:0]);
      if (image_type == image_type_raw) begin
         add_byte(8'(meta >> raw_pixel_shift));
      end else if (!enable_420) begin
         add_byte(rnd[23:16]);
         add_byte(rnd[15:8]);
         add_byte(rnd[7:0]);
      end else begin
         add_byte(rnd[23:16]);
         // odd row and odd column closes a 2x2 kernel
         if (r % 2 == 1 && c % 2 == 1) begin
            add_byte(kernel_mean(u_pix[r][c], u_pix[r-1][c], u_pix[r][c-1], u_pix[r-1][c-1]));
            add_byte(kernel_mean(v_pix[r][c], v_pix[r-1][c], v_pix[r][c-1], v_pix[r-1][c-1]));
         end
      end
   endtask

   task automatic send_frame_end(input int rows, input int cols);
      logic [word_width-1:0] pad;
      drive_beat(dtype_frame_end, 16'h0000, 8'h00, 8'h00, 8'h00);
      if (byte_q.size() > 0) begin
         pad = '0;
         foreach (byte_q[i]) begin
            pad[8*i +: 8] = byte_q[i];
         end
         expect_word(dtype_pixel, pad, 2);
         expect_word(dtype_frame_end, '0, 3);
         byte_q.delete();
      end else begin
         expect_word(dtype_frame_end, '0, 2);
      end
      idle_cycles(1);
      // size latched by the frame_end beat, rounded down to even
      exp_rows = dim_width'(rows - rows % 2);
      exp_cols = dim_width'(cols - cols % 2);
      idle_cycles(gap_cycles - 1);
   endtask

   task automatic run_frame(input int rows, input int cols);
      send_marker(dtype_frame_start);
      send_marker(dtype_header_start);
      for (int i = 0; i < 4; i++) begin
         send_header(i);
      end
      send_marker(dtype_header_end);
      for (int r = 0; r < rows; r++) begin
         send_marker(dtype_row_start);
         for (int c = 0; c < cols; c++) begin
            send_pixel(r, c);
         end
         send_marker(dtype_row_end);
      end
      send_frame_end(rows, cols);
   endtask

   task automatic set_mode(input string name, input logic [15:0] itype, input logic en);
      @(posedge clk);
      #2;
      test_name  = name;
      image_type = itype;
      enable_420 = en;
   endtask

   initial begin
      image_type = 16'h0003;
      enable_420 = 1'b0;
      dvi        = 1'b0;
      dtypei     = '0;
      meta_datai = '0;
      yi         = '0;
      ui         = '0;
      vi         = '0;
      wait (resetb === 1'b1);
      idle_cycles(4);
      set_mode("full_yuv", 16'h0003, 1'b0);
      run_frame(4, 6);
      set_mode("yuv420", 16'h0003, 1'b1);
      run_frame(4, 6);
      run_frame(4, 6);
      set_mode("raw", image_type_raw, 1'b0);
      run_frame(4, 6);
      // 3x5 in 420 leaves three bytes for the flush word
      set_mode("flush", 16'h0011, 1'b1);
      run_frame(3, 5);
      while (exp_type_q.size() != 0) begin
         @(posedge clk);
      end
      idle_cycles(4);
      assert (words_seen > 0)
         else begin
            errors++;
            $display("no output words were checked");
         end
      $display("words checked: %0d  errors: %0d", words_seen, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired with %0d output words still expected", exp_type_q.size());
      $display("words checked: %0d  errors: %0d", words_seen, errors);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: files.f
hdl/yuv420_pkg.sv
hdl/beat_if.sv
hdl/frame_position.sv
hdl/chroma_subsampler.sv
hdl/word_packer.sv
hdl/yuv420_stream.sv
verif/tb_clock_gen.sv
verif/tb_yuv420_stream.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_yuv420_stream -o sim_tb
if ! ./obj_dir/sim_tb > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
   exit 1
fi
grep -q "Simulation finished: PASS" sim.log
